// File: filelist.f
hw/debug_pkg.sv
hw/debug_bus_decode.sv
hw/debug_halt_ctrl.sv
hw/debug_pc_track.sv
hw/debug_rdata_mux.sv
hw/debug_unit_top.sv
dv/debug_unit_tb.sv

// File: dv/debug_unit_tb.sv
/*
  testbench for the debug unit
  - clock, reset, core ack model and register file model
  - bus read / write tasks, reference read value
  - compare process on every rvalid, watchdog
*/

`timescale 1ns/1ps
`default_nettype none

module debug_unit_tb import debug_pkg::*; ();

  localparam int CLK_PERIOD        = 20;
  localparam int NUM_ACCESSES      = 80;  // rough count over all tests
  localparam int CYCLES_PER_ACCESS = 200;

  // bus addresses
  localparam dbg_addr_t CTRL_ADDR  = 15'h0000;
  localparam dbg_addr_t HIT_ADDR   = 15'h0004;
  localparam dbg_addr_t IE_ADDR    = 15'h0008;
  localparam dbg_addr_t CAUSE_ADDR = 15'h000C;
  localparam dbg_addr_t DNPC_ADDR  = 15'h2000;
  localparam dbg_addr_t DPPC_ADDR  = 15'h2004;

  logic          clk;
  logic          rst_n;
  logic          debug_req_i;
  logic          debug_we_i;
  dbg_addr_t     debug_addr_i;
  word_t         debug_wdata_i;
  logic          debug_gnt_o;
  logic          debug_rvalid_o;
  word_t         debug_rdata_o;
  logic          debug_halted_o;
  logic          debug_halt_i;
  logic          debug_resume_i;
  dbg_settings_t settings_o;
  logic          trap_i;
  dbg_cause_t    exc_cause_i;
  logic          stall_o;
  logic          dbg_req_o;
  logic          dbg_ack_i;
  logic          regfile_rreq_o;
  reg_addr_t     regfile_raddr_o;
  word_t         regfile_rdata_i;
  logic          regfile_wreq_o;
  reg_addr_t     regfile_waddr_o;
  word_t         regfile_wdata_o;
  word_t         pc_if_i;
  word_t         pc_id_i;
  word_t         pc_ex_i;
  logic          data_load_event_i;
  logic          instr_valid_id_i;
  logic          sleeping_i;
  logic          branch_in_ex_i;
  logic          branch_taken_i;
  logic          jump_req_o;
  word_t         jump_addr_o;

  word_t      rf_mem [32];  // register file model
  word_t      exp_gpr [32]; // expected register contents
  logic       m_halted;     // model of the debug state
  logic       m_sste;
  logic       m_hit;
  logic       m_ecall;
  logic       m_elsu;
  logic       m_ebrk;
  logic       m_eill;
  dbg_cause_t m_cause;
  pc_track_e  m_track;
  integer     seed = 58056;
  int         error_count;
  logic       prev_req;     // access granted last cycle
  logic       prev_we;
  dbg_addr_t  prev_addr;

  debug_unit_top debug_unit_top_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .debug_req_i       (debug_req_i),
    .debug_gnt_o       (debug_gnt_o),
    .debug_rvalid_o    (debug_rvalid_o),
    .debug_addr_i      (debug_addr_i),
    .debug_we_i        (debug_we_i),
    .debug_wdata_i     (debug_wdata_i),
    .debug_rdata_o     (debug_rdata_o),
    .debug_halted_o    (debug_halted_o),
    .debug_halt_i      (debug_halt_i),
    .debug_resume_i    (debug_resume_i),
    .settings_o        (settings_o),
    .trap_i            (trap_i),
    .exc_cause_i       (exc_cause_i),
    .stall_o           (stall_o),
    .dbg_req_o         (dbg_req_o),
    .dbg_ack_i         (dbg_ack_i),
    .regfile_rreq_o    (regfile_rreq_o),
    .regfile_raddr_o   (regfile_raddr_o),
    .regfile_rdata_i   (regfile_rdata_i),
    .regfile_wreq_o    (regfile_wreq_o),
    .regfile_waddr_o   (regfile_waddr_o),
    .regfile_wdata_o   (regfile_wdata_o),
    .pc_if_i           (pc_if_i),
    .pc_id_i           (pc_id_i),
    .pc_ex_i           (pc_ex_i),
    .data_load_event_i (data_load_event_i),
    .instr_valid_id_i  (instr_valid_id_i),
    .sleeping_i        (sleeping_i),
    .branch_in_ex_i    (branch_in_ex_i),
    .branch_taken_i    (branch_taken_i),
    .jump_req_o        (jump_req_o),
    .jump_addr_o       (jump_addr_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------
  // core and register file models
  // ----------------------------------------
  assign regfile_rdata_i = regfile_rreq_o ? rf_mem[regfile_raddr_o] : '0;

  always @(posedge clk) begin
    if (regfile_wreq_o) rf_mem[regfile_waddr_o] <= regfile_wdata_o;
  end

  initial begin : core_ack
    int req_cycles;
    req_cycles = 0;
    forever begin
      @(negedge clk);
      if (dbg_req_o && !dbg_ack_i) req_cycles = req_cycles + 1;
      else                         req_cycles = 0;
      if (req_cycles == 2) begin // ack two cycles after the request
        @(posedge clk);
        dbg_ack_i <= 1'b1;
        @(posedge clk);
        dbg_ack_i <= 1'b0;
        req_cycles = 0;
      end
    end
  end

  // ----------------------------------------
  // reference values
  // ----------------------------------------
  function automatic word_t fill_word(input int i);
    return 32'h5A5A_0000 ^ (i * 32'h0001_0203);
  endfunction

  function automatic word_t expected_read(input dbg_addr_t addr);
    word_t     val;
    reg_addr_t idx;
    val = '0;
    idx = addr[6:2];
    if (!addr[14]) begin
      if (addr[13:8] == 6'h00) begin
        case (idx)
          5'd0: begin
            val[16] = m_halted;
            val[0]  = m_sste;
          end
          5'd1: begin
            val[16] = sleeping_i;
            val[0]  = m_hit;
          end
          5'd2: begin
            val[11] = m_ecall;
            val[7]  = m_elsu;  // elsu in both bits
            val[5]  = m_elsu;
            val[3]  = m_ebrk;
            val[2]  = m_eill;
          end
          5'd3: begin
            val[31]  = m_cause[5];
            val[4:0] = m_cause[4:0];
          end
          default: val = '0;
        endcase
      end else if (addr[13:8] == 6'h20) begin
        if (addr[2]) val = (m_track == IFID) ? pc_id_i : pc_ex_i; // ppc
        else         val = (m_track == IDEX) ? pc_id_i : pc_if_i; // npc
      end else if (addr[13:8] == 6'h04 && m_halted) begin
        val = exp_gpr[idx];
      end
    end
    return val;
  endfunction

  function automatic dbg_settings_t expected_settings();
    dbg_settings_t s;
    s                 = '0;
    s[DBG_SETS_SSTE]  = m_sste;
    s[DBG_SETS_ECALL] = m_ecall;
    s[DBG_SETS_ELSU]  = m_elsu;
    s[DBG_SETS_EBRK]  = m_ebrk;
    s[DBG_SETS_EILL]  = m_eill;
    return s;
  endfunction

  function automatic dbg_addr_t gpr_addr(input reg_addr_t idx);
    return {1'b0, 6'h04, 1'b0, idx, 2'b00};
  endfunction

  task automatic check_eq(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  // ----------------------------------------
  // bus and pin tasks
  // ----------------------------------------
  task automatic bus_write(input dbg_addr_t addr, input word_t data);
    logic exp_wreq;
    exp_wreq = m_halted && !addr[14] && (addr[13:8] == 6'h04);
    @(posedge clk);
    debug_req_i   <= 1'b1;
    debug_we_i    <= 1'b1;
    debug_addr_i  <= addr;
    debug_wdata_i <= data;
    @(negedge clk);
    check_eq("regfile_wreq_o", regfile_wreq_o, exp_wreq);
    @(posedge clk);
    debug_req_i <= 1'b0;
    debug_we_i  <= 1'b0;
    // write effects on the model
    if (!addr[14] && addr[13:8] == 6'h00) begin
      case (addr[6:2])
        5'd0: begin
          if (data[16] && !m_halted) m_cause = 6'h1F; // halt follows
          if (!data[16] && m_halted) begin
            m_halted = 1'b0;
            m_hit    = 1'b0; // cleared once running
          end
          m_sste = data[0];
        end
        5'd1: if (data[0]) m_hit = 1'b0;
        5'd2: begin
          m_ecall = data[11];
          m_elsu  = data[7] | data[5];
          m_ebrk  = data[3];
          m_eill  = data[2];
        end
        default: ;
      endcase
    end else if (!addr[14] && m_halted && addr[13:8] == 6'h20 && addr[6:2] == 5'd0) begin
      if (m_track == IDEX) m_track = IFEX; // jump moves npc to if
    end else if (exp_wreq) begin
      exp_gpr[addr[6:2]] = data;
    end
  endtask

  task automatic bus_read(input dbg_addr_t addr);
    @(posedge clk);
    debug_req_i  <= 1'b1;
    debug_we_i   <= 1'b0;
    debug_addr_i <= addr;
    @(posedge clk);
    debug_req_i <= 1'b0;
    @(negedge clk);
    while (!debug_rvalid_o) @(negedge clk); // data checked by compare
  endtask

  // follows a halt request until the core is halted
  task automatic wait_halted();
    @(negedge clk);
    while (!dbg_ack_i) begin
      check_eq("dbg_req_o", dbg_req_o, 1'b1);
      @(negedge clk);
    end
    if (branch_in_ex_i)         m_track = branch_taken_i ? IFEX : IDEX;
    else if (data_load_event_i) m_track = instr_valid_id_i ? IDEX : IFEX;
    else                        m_track = IFID;
    @(negedge clk);
    check_eq("debug_halted_o", debug_halted_o, 1'b1);
    check_eq("stall_o", stall_o, 1'b1);
    m_halted = 1'b1;
  endtask

  task automatic trap_halt(input dbg_cause_t cause);
    @(posedge clk);
    trap_i      <= 1'b1;
    exc_cause_i <= cause;
    @(posedge clk);
    trap_i  <= 1'b0;
    m_cause = cause;
    m_hit   = m_sste; // step hit only with single-step on
    wait_halted();
  endtask

  task automatic pin_halt();
    @(posedge clk);
    debug_halt_i <= 1'b1;
    @(posedge clk);
    debug_halt_i <= 1'b0;
    m_cause = 6'h1F;
    wait_halted();
  endtask

  task automatic pin_resume();
    @(posedge clk);
    debug_resume_i <= 1'b1;
    @(negedge clk);
    check_eq("stall_o", stall_o, 1'b0); // drops in the resume cycle
    @(posedge clk);
    debug_resume_i <= 1'b0;
    m_halted = 1'b0;
    m_hit    = 1'b0;
  endtask

  // ----------------------------------------
  // compare process
  // ----------------------------------------
  initial begin : compare
    logic exp_rreq;
    prev_req  = 1'b0;
    prev_we   = 1'b0;
    prev_addr = '0;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (debug_req_i && !debug_gnt_o) begin
          $display("error at %0t ns: request was not granted in its own cycle", $time);
          error_count++;
        end
        if (!debug_req_i && debug_gnt_o) begin
          $display("error at %0t ns: grant raised without a request", $time);
          error_count++;
        end
        check_eq("debug_rvalid_o", debug_rvalid_o, prev_req);
        // gpr read request only in the rvalid cycle of a halted gpr read
        exp_rreq = prev_req && !prev_we && !prev_addr[14] && prev_addr[13:8] == 6'h04 &&
                   m_halted;
        check_eq("regfile_rreq_o", regfile_rreq_o, exp_rreq);
        if (debug_rvalid_o && prev_req && !prev_we) begin
          check_eq("debug_rdata_o", debug_rdata_o, expected_read(prev_addr));
        end
      end
      prev_req  = rst_n && debug_req_i;
      prev_we   = debug_we_i;
      prev_addr = debug_addr_i;
    end
  end

  initial begin : watchdog
    #(NUM_ACCESSES * CYCLES_PER_ACCESS * CLK_PERIOD);
    error_count++;
    $display("error: watchdog timeout, the tests did not finish in time");
    $display("errors: %0d", error_count);
    $display("Test failed");
    $finish;
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin : main
    word_t      data;
    dbg_cause_t cause;
    reg_addr_t  idx;

    rst_n             = 1'b0;
    debug_req_i       = 1'b0;
    debug_we_i        = 1'b0;
    debug_addr_i      = '0;
    debug_wdata_i     = '0;
    debug_halt_i      = 1'b0;
    debug_resume_i    = 1'b0;
    trap_i            = 1'b0;
    exc_cause_i       = '0;
    dbg_ack_i         = 1'b0;
    pc_if_i           = 32'h0000_1008;
    pc_id_i           = 32'h0000_1004;
    pc_ex_i           = 32'h0000_1000;
    data_load_event_i = 1'b0;
    instr_valid_id_i  = 1'b0;
    sleeping_i        = 1'b0;
    branch_in_ex_i    = 1'b0;
    branch_taken_i    = 1'b0;
    error_count       = 0;
    m_halted          = 1'b0;
    m_sste            = 1'b0;
    m_hit             = 1'b0;
    m_ecall           = 1'b0;
    m_elsu            = 1'b0;
    m_ebrk            = 1'b0;
    m_eill            = 1'b0;
    m_cause           = 6'h1F;
    m_track           = IFID;
    for (int i = 0; i < 32; i++) begin
      rf_mem[i]  = fill_word(i);
      exp_gpr[i] = fill_word(i);
    end

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // reset values, zero reads
    @(negedge clk);
    check_eq("settings_o", settings_o, '0);
    check_eq("stall_o", stall_o, 1'b0);
    check_eq("dbg_req_o", dbg_req_o, 1'b0);
    bus_read(CTRL_ADDR);
    bus_read(CAUSE_ADDR);
    bus_read(15'h4000 | CAUSE_ADDR); // addr bit 14 reads zero
    bus_read(15'h0040);              // breakpoint regs read zero

    // halt and resume by control writes
    bus_write(CTRL_ADDR, 32'h0001_0000);
    wait_halted();
    bus_read(CTRL_ADDR);
    bus_write(CTRL_ADDR, 32'h0000_0000);
    @(negedge clk);
    check_eq("debug_halted_o", debug_halted_o, 1'b0);
    check_eq("stall_o", stall_o, 1'b0);
    bus_read(CTRL_ADDR);

    // exception enables
    repeat (8) begin
      data = $random(seed);
      bus_write(IE_ADDR, data);
      @(negedge clk);
      check_eq("settings_o", settings_o, expected_settings());
      bus_read(IE_ADDR);
    end

    // gpr access, running then halted
    data = $random(seed);
    idx  = data[4:0];
    bus_write(gpr_addr(idx), $random(seed));
    @(negedge clk);
    check_eq("rf_mem entry", rf_mem[idx], exp_gpr[idx]);
    bus_read(gpr_addr(idx));
    bus_write(CTRL_ADDR, 32'h0001_0000);
    wait_halted();
    repeat (8) begin
      data = $random(seed);
      idx  = data[4:0];
      data = $random(seed);
      bus_write(gpr_addr(idx), data);
      @(negedge clk);
      check_eq("rf_mem entry", rf_mem[idx], data);
      bus_read(gpr_addr(idx));
    end
    bus_write(CTRL_ADDR, 32'h0000_0000);

    // single-step trap, cause and hit
    bus_write(CTRL_ADDR, 32'h0000_0001);
    @(posedge clk);
    sleeping_i <= 1'b1;
    data  = $random(seed);
    cause = data[5:0];
    trap_halt(cause);
    bus_read(CAUSE_ADDR);
    bus_read(HIT_ADDR);
    bus_write(HIT_ADDR, 32'h0000_0001);
    bus_read(HIT_ADDR);
    bus_write(CTRL_ADDR, 32'h0000_0000);

    // npc / ppc after a taken branch, then jump
    @(posedge clk);
    branch_in_ex_i <= 1'b1;
    branch_taken_i <= 1'b1;
    pc_if_i        <= $random(seed);
    pc_id_i        <= $random(seed);
    pc_ex_i        <= $random(seed);
    pin_halt();
    bus_read(DNPC_ADDR);
    bus_read(DPPC_ADDR);
    data = $random(seed);
    bus_write(DNPC_ADDR, data);
    @(negedge clk);
    check_eq("jump_req_o", jump_req_o, 1'b1);
    check_eq("jump_addr_o", jump_addr_o, data);
    @(negedge clk);
    check_eq("jump_req_o", jump_req_o, 1'b0); // single pulse
    pin_resume();
    bus_read(CTRL_ADDR);

    repeat (2) @(posedge clk);
    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/debug_unit_top.sv
/*
  debug unit top level
  - bus decoder, halt controller, pc tracker and read formatter
  - host debug bus on one side, core and register file on the other
*/

`timescale 1ns/1ps
`default_nettype none

module debug_unit_top import debug_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,

  // host debug bus
  input  logic          debug_req_i,
  output logic          debug_gnt_o,
  output logic          debug_rvalid_o,
  input  dbg_addr_t     debug_addr_i,
  input  logic          debug_we_i,
  input  word_t         debug_wdata_i,
  output word_t         debug_rdata_o,

  output logic          debug_halted_o,
  input  logic          debug_halt_i,
  input  logic          debug_resume_i,

  // core control
  output dbg_settings_t settings_o,
  input  logic          trap_i,
  input  dbg_cause_t    exc_cause_i,
  output logic          stall_o,
  output logic          dbg_req_o,
  input  logic          dbg_ack_i,

  // register file
  output logic          regfile_rreq_o,
  output reg_addr_t     regfile_raddr_o,
  input  word_t         regfile_rdata_i,
  output logic          regfile_wreq_o,
  output reg_addr_t     regfile_waddr_o,
  output word_t         regfile_wdata_o,

  // pipeline state for npc / ppc
  input  word_t         pc_if_i,
  input  word_t         pc_id_i,
  input  word_t         pc_ex_i,
  input  logic          data_load_event_i,
  input  logic          instr_valid_id_i,
  input  logic          sleeping_i,
  input  logic          branch_in_ex_i,
  input  logic          branch_taken_i,

  output logic          jump_req_o,
  output word_t         jump_addr_o
);

  logic       halt_req, resume_req, hit_clear;
  rdata_sel_e rdata_sel;
  reg_addr_t  reg_idx;
  dbg_cause_t cause;
  logic       ssth;
  word_t      npc, ppc;

  // ----------------------------------------
  // input side
  // ----------------------------------------
  debug_bus_decode debug_bus_decode_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .debug_req_i     (debug_req_i),
    .debug_we_i      (debug_we_i),
    .debug_addr_i    (debug_addr_i),
    .debug_wdata_i   (debug_wdata_i),
    .debug_gnt_o     (debug_gnt_o),
    .debug_rvalid_o  (debug_rvalid_o),
    .halted_i        (debug_halted_o),
    .settings_o      (settings_o),
    .halt_req_o      (halt_req),
    .resume_req_o    (resume_req),
    .hit_clear_o     (hit_clear),
    .rdata_sel_o     (rdata_sel),
    .reg_idx_o       (reg_idx),
    .regfile_rreq_o  (regfile_rreq_o),
    .regfile_raddr_o (regfile_raddr_o),
    .regfile_wreq_o  (regfile_wreq_o),
    .regfile_waddr_o (regfile_waddr_o),
    .regfile_wdata_o (regfile_wdata_o),
    .jump_req_o      (jump_req_o),
    .jump_addr_o     (jump_addr_o)
  );

  // ----------------------------------------
  // halt control and pc tracking
  // ----------------------------------------
  debug_halt_ctrl debug_halt_ctrl_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .halt_req_i     (halt_req),
    .resume_req_i   (resume_req),
    .hit_clear_i    (hit_clear),
    .sste_i         (settings_o[DBG_SETS_SSTE]),
    .debug_halt_i   (debug_halt_i),
    .debug_resume_i (debug_resume_i),
    .trap_i         (trap_i),
    .exc_cause_i    (exc_cause_i),
    .dbg_ack_i      (dbg_ack_i),
    .dbg_req_o      (dbg_req_o),
    .stall_o        (stall_o),
    .halted_o       (debug_halted_o),
    .cause_o        (cause),
    .ssth_o         (ssth)
  );

  debug_pc_track debug_pc_track_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .pc_if_i           (pc_if_i),
    .pc_id_i           (pc_id_i),
    .pc_ex_i           (pc_ex_i),
    .dbg_ack_i         (dbg_ack_i),
    .branch_in_ex_i    (branch_in_ex_i),
    .branch_taken_i    (branch_taken_i),
    .data_load_event_i (data_load_event_i),
    .instr_valid_id_i  (instr_valid_id_i),
    .jump_req_i        (jump_req_o),
    .npc_o             (npc),
    .ppc_o             (ppc)
  );

  // output side
  debug_rdata_mux debug_rdata_mux_inst (
    .rdata_sel_i     (rdata_sel),
    .reg_idx_i       (reg_idx),
    .halted_i        (debug_halted_o),
    .settings_i      (settings_o),
    .sleeping_i      (sleeping_i),
    .ssth_i          (ssth),
    .cause_i         (cause),
    .npc_i           (npc),
    .ppc_i           (ppc),
    .regfile_rdata_i (regfile_rdata_i),
    .debug_rdata_o   (debug_rdata_o)
  );

endmodule

`default_nettype wire

// File: hw/debug_rdata_mux.sv
/*
  read data formatter
  - layout of ctrl, hit, ie and cause as seen on the bus
  - npc / ppc in the halted region
  - final select between gpr, debug register or zero
*/

`timescale 1ns/1ps
`default_nettype none

module debug_rdata_mux import debug_pkg::*; (
  input  rdata_sel_e    rdata_sel_i,
  input  reg_addr_t     reg_idx_i,

  input  logic          halted_i,
  input  dbg_settings_t settings_i,
  input  logic          sleeping_i,
  input  logic          ssth_i,
  input  dbg_cause_t    cause_i,

  input  word_t         npc_i,
  input  word_t         ppc_i,
  input  word_t         regfile_rdata_i,

  output word_t         debug_rdata_o
);

  word_t dbga_rdata; // always region
  word_t dbgs_rdata; // halted region

  // ----------------------------------------
  // always accessible registers
  // ----------------------------------------
  always_comb begin
    dbga_rdata = '0;
    case (reg_idx_i)
      DBG_REG_CTRL: begin
        dbga_rdata[DBG_CTRL_HALT_BIT] = halted_i;
        dbga_rdata[0]                 = settings_i[DBG_SETS_SSTE];
      end
      DBG_REG_HIT: begin
        dbga_rdata[16] = sleeping_i; // core in sleep
        dbga_rdata[0]  = ssth_i;
      end
      DBG_REG_IE: begin
        // elsu shows up in both of its bits
        dbga_rdata = {32{settings_i[DBG_SETS_ELSU]}} & DBG_IE_ELSU_BITS;
        dbga_rdata[DBG_IE_ECALL_BIT] = settings_i[DBG_SETS_ECALL];
        dbga_rdata[DBG_IE_EBRK_BIT]  = settings_i[DBG_SETS_EBRK];
        dbga_rdata[DBG_IE_EILL_BIT]  = settings_i[DBG_SETS_EILL];
      end
      DBG_REG_CAUSE: dbga_rdata = {cause_i[5], 26'b0, cause_i[4:0]}; // irq flag on top
      default: ; // breakpoint regs etc read zero
    endcase
  end

  assign dbgs_rdata = reg_idx_i[0] ? ppc_i : npc_i; // dnpc at 0, dppc at 1

  // ----------------------------------------
  // output select
  // ----------------------------------------
  always_comb begin
    case (rdata_sel_i)
      RD_GPR:  debug_rdata_o = regfile_rdata_i;
      RD_DBGA: debug_rdata_o = dbga_rdata;
      RD_DBGS: debug_rdata_o = dbgs_rdata;
      default: debug_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/debug_pc_track.sv
/*
  npc / ppc tracking
  - remembers which pipeline stages hold the next and previous pc
    when the core acks a halt
  - selects npc and ppc from the stage pcs
*/

`timescale 1ns/1ps
`default_nettype none

module debug_pc_track import debug_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,

  input  word_t pc_if_i,
  input  word_t pc_id_i,
  input  word_t pc_ex_i,

  input  logic  dbg_ack_i,
  input  logic  branch_in_ex_i,
  input  logic  branch_taken_i,
  input  logic  data_load_event_i,
  input  logic  instr_valid_id_i,
  input  logic  jump_req_i,

  output word_t npc_o,
  output word_t ppc_o
);

  pc_track_e state_q, state_n;

  // ----------------------------------------
  // stage select
  // ----------------------------------------
  always_comb begin
    state_n = state_q;
    ppc_o   = pc_id_i;
    npc_o   = pc_if_i;

    case (state_q)
      IFEX: ppc_o = pc_ex_i;
      IDEX: begin
        ppc_o = pc_ex_i;
        npc_o = pc_id_i;
        if (jump_req_i) state_n = IFEX; // new npc now fetched in if
      end
      default: ; // IFID
    endcase

    // halt acked, find out where the pcs sit
    if (dbg_ack_i) begin
      if (branch_in_ex_i) begin
        state_n = branch_taken_i ? IFEX : IDEX;
      end else if (data_load_event_i) begin
        state_n = instr_valid_id_i ? IDEX : IFEX; // event load stalls in ex
      end else begin
        state_n = IFID;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state_q <= IFID;
    else        state_q <= state_n;
  end

endmodule

`default_nettype wire

// File: hw/debug_halt_ctrl.sv
/*
  halt controller
  - running / halt request / halted state machine
  - halt cause register
  - single-step hit flag
*/

`timescale 1ns/1ps
`default_nettype none

module debug_halt_ctrl import debug_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  input  logic       halt_req_i,   // from control write
  input  logic       resume_req_i,
  input  logic       hit_clear_i,
  input  logic       sste_i,       // single-step enabled

  input  logic       debug_halt_i, // pins
  input  logic       debug_resume_i,

  input  logic       trap_i,
  input  dbg_cause_t exc_cause_i,
  input  logic       dbg_ack_i,

  output logic       dbg_req_o,
  output logic       stall_o,
  output logic       halted_o,
  output dbg_cause_t cause_o,
  output logic       ssth_o
);

  halt_state_e state_q, state_n;
  dbg_cause_t  cause_q, cause_n;
  logic        ssth_q, ssth_n;
  logic        resume;

  assign resume = resume_req_i | debug_resume_i;

  always_comb begin
    state_n   = state_q;
    cause_n   = cause_q;
    ssth_n    = ssth_q;
    dbg_req_o = 1'b0;
    stall_o   = 1'b0;
    halted_o  = 1'b0;

    case (state_q)
      RUNNING: begin
        ssth_n = 1'b0;
        if (halt_req_i || debug_halt_i || trap_i) begin
          dbg_req_o = 1'b1; // same cycle as the request
          state_n   = HALT_REQ;
          if (trap_i) begin
            cause_n = exc_cause_i;
            ssth_n  = sste_i; // step hit
          end else begin
            cause_n = DBG_CAUSE_HALT;
          end
        end
      end
      HALT_REQ: begin
        dbg_req_o = 1'b1; // hold until core acks
        if (dbg_ack_i) state_n = HALT;
        if (resume)    state_n = RUNNING; // cancels the request
      end
      HALT: begin
        stall_o  = !resume; // release stall right away
        halted_o = 1'b1;
        if (resume) state_n = RUNNING;
      end
      default: state_n = RUNNING;
    endcase

    if (hit_clear_i) ssth_n = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RUNNING;
      cause_q <= DBG_CAUSE_HALT;
      ssth_q  <= 1'b0;
    end else begin
      state_q <= state_n;
      cause_q <= cause_n;
      ssth_q  <= ssth_n;
    end
  end

  assign cause_o = cause_q;
  assign ssth_o  = ssth_q;

endmodule

`default_nettype wire

// File: hw/debug_bus_decode.sv
/*
  debug bus decoder
  - grants every request, rvalid one cycle later
  - settings register (single-step and exception enables)
  - halt / resume / hit clear pulses from control writes
  - register file read and write requests, jump request on dnpc write
*/

`timescale 1ns/1ps
`default_nettype none

module debug_bus_decode import debug_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,

  // host bus
  input  logic          debug_req_i,
  input  logic          debug_we_i,
  input  dbg_addr_t     debug_addr_i,
  input  word_t         debug_wdata_i,
  output logic          debug_gnt_o,
  output logic          debug_rvalid_o,

  input  logic          halted_i,

  // to halt controller and core
  output dbg_settings_t settings_o,
  output logic          halt_req_o,
  output logic          resume_req_o,
  output logic          hit_clear_o,

  // to read formatter
  output rdata_sel_e    rdata_sel_o,
  output reg_addr_t     reg_idx_o,

  // register file
  output logic          regfile_rreq_o,
  output reg_addr_t     regfile_raddr_o,
  output logic          regfile_wreq_o,
  output reg_addr_t     regfile_waddr_o,
  output word_t         regfile_wdata_o,

  // jump
  output logic          jump_req_o,
  output word_t         jump_addr_o
);

  logic [5:0]    region;
  reg_addr_t     idx;

  dbg_settings_t settings_q, settings_n;
  rdata_sel_e    rdata_sel_q, rdata_sel_n;
  logic          rreq_q, rreq_n;
  logic          jump_q, jump_n;
  logic          rvalid_q;

  reg_addr_t     idx_q;   // latched word index
  word_t         wdata_q; // latched write data, jump target

  assign region = debug_addr_i[13:8];
  assign idx    = debug_addr_i[6:2];

  assign debug_gnt_o = debug_req_i; // never refused, invalid accesses too

  // ----------------------------------------
  // access decode
  // ----------------------------------------
  always_comb begin
    settings_n     = settings_q;
    rdata_sel_n    = RD_NONE; // reads zero unless decoded below
    rreq_n         = 1'b0;
    jump_n         = 1'b0;
    halt_req_o     = 1'b0;
    resume_req_o   = 1'b0;
    hit_clear_o    = 1'b0;
    regfile_wreq_o = 1'b0;

    // addr[14] set: granted, no effect
    if (debug_req_i && !debug_addr_i[14]) begin
      if (debug_we_i) begin
        case (region)
          DBG_REGION_ALWAYS: begin
            case (idx)
              DBG_REG_CTRL: begin
                if (debug_wdata_i[DBG_CTRL_HALT_BIT]) begin
                  halt_req_o = !halted_i; // only if still running
                end else begin
                  resume_req_o = halted_i;
                end
                settings_n[DBG_SETS_SSTE] = debug_wdata_i[0];
              end
              DBG_REG_HIT: hit_clear_o = debug_wdata_i[0];
              DBG_REG_IE: begin
                settings_n[DBG_SETS_ECALL] = debug_wdata_i[DBG_IE_ECALL_BIT];
                settings_n[DBG_SETS_ELSU]  = |(debug_wdata_i & DBG_IE_ELSU_BITS);
                settings_n[DBG_SETS_EBRK]  = debug_wdata_i[DBG_IE_EBRK_BIT];
                settings_n[DBG_SETS_EILL]  = debug_wdata_i[DBG_IE_EILL_BIT];
              end
              default: ; // cause is read only
            endcase
          end
          DBG_REGION_HALTED: jump_n = halted_i && (idx == '0); // dnpc
          DBG_REGION_GPR:    regfile_wreq_o = halted_i;
          default: ;
        endcase
      end else begin
        case (region)
          DBG_REGION_ALWAYS: rdata_sel_n = RD_DBGA;
          DBG_REGION_HALTED: rdata_sel_n = RD_DBGS;
          DBG_REGION_GPR: begin
            if (halted_i) begin
              rreq_n      = 1'b1;
              rdata_sel_n = RD_GPR;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // ----------------------------------------
  // control registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q    <= 1'b0;
      settings_q  <= '0;
      rdata_sel_q <= RD_NONE;
      rreq_q      <= 1'b0;
      jump_q      <= 1'b0;
    end else begin
      rvalid_q   <= debug_gnt_o;
      settings_q <= settings_n;
      // update on req or rvalid so single pulses drop after one cycle
      if (debug_req_i || rvalid_q) begin
        rdata_sel_q <= rdata_sel_n;
        rreq_q      <= rreq_n;
        jump_q      <= jump_n;
      end
    end
  end

  // address and data latch
  always_ff @(posedge clk) begin
    if (debug_req_i) begin
      idx_q   <= idx;
      wdata_q <= debug_wdata_i;
    end
  end

  assign debug_rvalid_o  = rvalid_q;
  assign settings_o      = settings_q;
  assign rdata_sel_o     = rdata_sel_q;
  assign reg_idx_o       = idx_q;

  assign regfile_rreq_o  = rreq_q;
  assign regfile_raddr_o = idx_q;
  assign regfile_waddr_o = idx;           // write goes straight through
  assign regfile_wdata_o = debug_wdata_i;

  assign jump_req_o      = jump_q;
  assign jump_addr_o     = wdata_q;

endmodule

`default_nettype wire

// File: hw/debug_pkg.sv
/*
  shared definitions for the debug unit
  - widths of data words, bus addresses, register indices, cause and settings
  - address map of the debug bus, register word indices
  - bit positions within the settings vector and the debug registers
  - state encodings of the read select, halt controller and pc tracker
*/

`default_nettype none

package debug_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int unsigned DBG_SETS_W = 5;

  typedef logic [31:0]           word_t;         // bus data, gpr and pc
  typedef logic [14:0]           dbg_addr_t;     // byte address on the debug bus
  typedef logic [4:0]            reg_addr_t;     // gpr / debug reg word index
  typedef logic [5:0]            dbg_cause_t;    // halt cause
  typedef logic [DBG_SETS_W-1:0] dbg_settings_t; // settings driven to the core

  // settings vector bit indices
  localparam int unsigned DBG_SETS_SSTE  = 0; // single-step enable
  localparam int unsigned DBG_SETS_ECALL = 1;
  localparam int unsigned DBG_SETS_ELSU  = 2; // load/store unit exceptions
  localparam int unsigned DBG_SETS_EBRK  = 3;
  localparam int unsigned DBG_SETS_EILL  = 4;

  localparam dbg_cause_t DBG_CAUSE_HALT = 6'h1F; // halt without a trap

  // ----------------------------------------
  // address map
  // ----------------------------------------
  // regions on addr[13:8]
  localparam logic [5:0] DBG_REGION_ALWAYS = 6'h00; // always accessible
  localparam logic [5:0] DBG_REGION_HALTED = 6'h20; // npc / ppc
  localparam logic [5:0] DBG_REGION_GPR    = 6'h04; // register file

  // word index on addr[6:2], always region
  localparam reg_addr_t DBG_REG_CTRL  = 5'd0;
  localparam reg_addr_t DBG_REG_HIT   = 5'd1;
  localparam reg_addr_t DBG_REG_IE    = 5'd2;
  localparam reg_addr_t DBG_REG_CAUSE = 5'd3;

  localparam int unsigned DBG_CTRL_HALT_BIT = 16;

  // exception enable register layout
  localparam int unsigned DBG_IE_ECALL_BIT = 11;
  localparam word_t       DBG_IE_ELSU_BITS = 32'h0000_00A0; // bits 7 and 5
  localparam int unsigned DBG_IE_EBRK_BIT  = 3;
  localparam int unsigned DBG_IE_EILL_BIT  = 2;

  // ----------------------------------------
  // state encodings
  // ----------------------------------------
  typedef enum logic [1:0] {RD_NONE, RD_GPR, RD_DBGA, RD_DBGS} rdata_sel_e;

  typedef enum logic [1:0] {RUNNING, HALT_REQ, HALT} halt_state_e;

  typedef enum logic [1:0] {IFID, IFEX, IDEX} pc_track_e;

endpackage

`default_nettype wire
